// ==== logic/kbd_pkg.sv ====
// ==============================
// shared types and constants for the PC keyboard port
// imported by every RTL block and by the testbench
// ==============================
package kbd_pkg;

	// one keyboard byte, scan set 2 on the wire and set 1 toward the PC
	typedef logic [7:0] scan_code_t;

	// port A handshake states
	typedef enum logic [2:0] {
		st_idle,       // waiting for a frame
		st_hold,       // result on pa, irq1 high
		st_wait_clear, // irq1 dropped, waiting for pb7 to fall
		st_break,      // F0 seen, next code is a release
		st_reset_low,  // pb6 held low by the PC
		st_reset_wait  // pb6 released, waiting for pb7 low
	} port_state_e;

	// set 2 break prefix
	localparam scan_code_t BREAK_PREFIX = 8'hf0;

	// keyboard self-test passed reply
	localparam scan_code_t SELF_TEST_OK = 8'haa;

	// release flag in a set 1 code
	localparam int BREAK_BIT = 7;

	// start, 8 data, parity, stop
	localparam int FRAME_BITS = 11;

	// wide enough to count FRAME_BITS edges
	localparam int BIT_COUNT_W = 4;

endpackage

// ==== logic/ps2_sampler.sv ====
// ==============================
// PS/2 line sampler in the clk domain
// synchronizes both keyboard lines, flags falling keyboard
// clock edges and assembles the data byte of each frame
// ==============================
`timescale 1ns/1ns

module ps2_sampler (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                ps2_clk,
	input  logic                ps2_data,
	input  logic                frame_done,
	output logic                fall_edge,
	output kbd_pkg::scan_code_t rx_code
);
	import kbd_pkg::*;

	logic [2:0] clk_sync;  // two sync stages plus one of history
	logic [1:0] data_sync;
	logic [FRAME_BITS-2:0] frame_reg;  // bits received so far
	logic [FRAME_BITS-1:0] frame_next; // frame including the current bit
	scan_code_t code_reg;  // last complete byte

	// both lines idle high
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			clk_sync <= '1;
			data_sync <= '1;
		end else begin
			clk_sync <= {clk_sync[1:0], ps2_clk};
			data_sync <= {data_sync[0], ps2_data};
		end
	end

	// high for one cycle after the synced clock goes low
	assign fall_edge = clk_sync[2] & ~clk_sync[1];

	// lsb first, so the newest bit enters at the top
	assign frame_next = {data_sync[1], frame_reg};

	always_ff @(posedge clk) begin
		if (fall_edge)
			frame_reg <= frame_next[FRAME_BITS-1:1];
	end

	// start bit sits at 0, parity and stop above the data
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			code_reg <= '0;
		else if (frame_done)
			code_reg <= frame_next[8:1];
	end

	// new byte is visible in the frame_done cycle itself
	assign rx_code = frame_done ? frame_next[8:1] : code_reg;

endmodule

// ==== logic/ps2_bit_counter.sv ====
// ==============================
// frame position counter for the PS/2 receiver
// pulses frame_done on the last clock edge of a frame and
// drops a partial frame after a quiet period
// ==============================
`timescale 1ns/1ns

module ps2_bit_counter #(
	parameter int IDLE_TIMEOUT = 64
) (
	input  logic clk,
	input  logic rst_n,
	input  logic fall_edge,
	output logic frame_done
);
	import kbd_pkg::*;

	localparam int IDLE_W = $clog2(IDLE_TIMEOUT + 1);

	logic [BIT_COUNT_W-1:0] bit_cnt;  // edges seen in this frame
	logic [IDLE_W-1:0] idle_cnt;      // cycles since the last edge
	logic idle_expired;

	// same cycle as the last edge
	assign frame_done = fall_edge && (bit_cnt == BIT_COUNT_W'(FRAME_BITS - 1));

	assign idle_expired = (idle_cnt == IDLE_W'(IDLE_TIMEOUT));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt <= '0;
			idle_cnt <= '0;
		end else if (fall_edge) begin
			idle_cnt <= '0;
			if (frame_done)
				bit_cnt <= '0;
			else
				bit_cnt <= bit_cnt + 1'b1;
		end else if (idle_expired) begin
			// keyboard went quiet mid frame, realign on the next start bit
			bit_cnt <= '0;
		end else begin
			idle_cnt <= idle_cnt + 1'b1; // stops at IDLE_TIMEOUT
		end
	end

endmodule

// ==== logic/scan_translate.sv ====
// ==============================
// scan set 2 to scan set 1 lookup, purely combinational
// also flags the F0 break prefix for the port state machine
// ==============================
`timescale 1ns/1ns

module scan_translate (
	input  kbd_pkg::scan_code_t rx_code,
	output kbd_pkg::scan_code_t set1_code,
	output logic                is_break
);
	import kbd_pkg::*;

	// set 1 codes for set 2 codes 00 to 7f, eight per line
	localparam scan_code_t SET1_TABLE [128] = '{
		8'hff, 8'h43, 8'h41, 8'h3f, 8'h3d, 8'h3b, 8'h3c, 8'h58,
		8'h64, 8'h44, 8'h42, 8'h40, 8'h3e, 8'h0f, 8'h29, 8'h59,
		8'h65, 8'h38, 8'h2a, 8'h70, 8'h1d, 8'h10, 8'h02, 8'h5a,
		8'h66, 8'h71, 8'h2c, 8'h1f, 8'h1e, 8'h11, 8'h03, 8'h5b,
		8'h67, 8'h2e, 8'h2d, 8'h20, 8'h12, 8'h05, 8'h04, 8'h5c,
		8'h68, 8'h39, 8'h2f, 8'h21, 8'h14, 8'h13, 8'h06, 8'h5d,
		8'h69, 8'h31, 8'h30, 8'h23, 8'h22, 8'h15, 8'h07, 8'h5e,
		8'h6a, 8'h72, 8'h32, 8'h24, 8'h16, 8'h08, 8'h09, 8'h5f,
		8'h6b, 8'h33, 8'h25, 8'h17, 8'h18, 8'h0b, 8'h0a, 8'h60,
		8'h6c, 8'h34, 8'h35, 8'h26, 8'h27, 8'h19, 8'h0c, 8'h61,
		8'h6d, 8'h73, 8'h28, 8'h74, 8'h1a, 8'h0d, 8'h62, 8'h6e,
		8'h3a, 8'h36, 8'h1c, 8'h1b, 8'h75, 8'h2b, 8'h63, 8'h76,
		8'h55, 8'h56, 8'h77, 8'h78, 8'h79, 8'h7a, 8'h0e, 8'h7b,
		8'h7c, 8'h4f, 8'h7d, 8'h4b, 8'h47, 8'h7e, 8'h7f, 8'h6f,
		8'h52, 8'h53, 8'h50, 8'h4c, 8'h4d, 8'h48, 8'h01, 8'h45,
		8'h57, 8'h4e, 8'h51, 8'h4a, 8'h37, 8'h49, 8'h46, 8'h54
	};

	always_comb begin
		if (!rx_code[7]) begin
			set1_code = SET1_TABLE[rx_code[6:0]];
		end else begin
			case (rx_code)
				8'h83: set1_code = 8'h41; // F7
				8'h84: set1_code = 8'h54; // alt sysrq
				default: set1_code = rx_code; // upper half passes through
			endcase
		end
	end

	assign is_break = (rx_code == BREAK_PREFIX);

endmodule

// ==== logic/port_a_fsm.sv ====
// ==============================
// port A handshake toward the PC
// drives pa and irq1 from received codes, clears on pb7 and
// answers a pb6 keyboard reset with the self-test code
// ==============================
`timescale 1ns/1ns

module port_a_fsm (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                frame_done,
	input  kbd_pkg::scan_code_t set1_code,
	input  logic                is_break,
	input  logic                pb6,
	input  logic                pb7,
	output kbd_pkg::scan_code_t pa,
	output logic                irq1
);
	import kbd_pkg::*;

	port_state_e state;
	scan_code_t break_code; // release form of the current code

	always_comb begin
		break_code = set1_code;
		break_code[BREAK_BIT] = 1'b1;
	end

	// frames that end outside st_idle and st_break are dropped
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			pa <= '0;
			irq1 <= 1'b0;
		end else if (!pb6) begin
			// keyboard reset wins over whatever is pending
			state <= st_reset_low;
			irq1 <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (frame_done) begin
						if (is_break) begin
							state <= st_break;
						end else begin
							pa <= set1_code;
							irq1 <= 1'b1;
							state <= st_hold;
						end
					end
				end
				st_break: begin
					// a second F0 keeps waiting for the real code
					if (frame_done && !is_break) begin
						pa <= break_code;
						irq1 <= 1'b1;
						state <= st_hold;
					end
				end
				st_hold: begin
					if (pb7) begin
						irq1 <= 1'b0; // pa keeps the result
						state <= st_wait_clear;
					end
				end
				st_wait_clear: begin
					if (!pb7) begin
						pa <= '0;
						state <= st_idle;
					end
				end
				st_reset_low: begin
					state <= st_reset_wait; // pb6 is back high here
				end
				st_reset_wait: begin
					if (!pb7) begin
						pa <= SELF_TEST_OK;
						irq1 <= 1'b1;
						state <= st_hold;
					end
				end
				default: begin
					pa <= '0;
					irq1 <= 1'b0;
					state <= st_idle;
				end
			endcase
		end
	end

endmodule

// ==== logic/kbd_port_top.sv ====
// ==============================
// IBM PC keyboard port, top level
// PS/2 keyboard lines in, port A byte and irq1 out
// ==============================
`timescale 1ns/1ns

module kbd_port_top #(
	parameter int IDLE_TIMEOUT = 64
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                ps2_clk,
	input  logic                ps2_data,
	input  logic                pb6,
	input  logic                pb7,
	output kbd_pkg::scan_code_t pa,
	output logic                irq1
);
	import kbd_pkg::*;

	logic fall_edge;
	logic frame_done;
	logic is_break;
	scan_code_t rx_code;   // raw set 2 byte
	scan_code_t set1_code; // translated byte

	ps2_sampler i_sampler (
		.clk        (clk),
		.rst_n      (rst_n),
		.ps2_clk    (ps2_clk),
		.ps2_data   (ps2_data),
		.frame_done (frame_done),
		.fall_edge  (fall_edge),
		.rx_code    (rx_code)
	);

	ps2_bit_counter #(
		.IDLE_TIMEOUT (IDLE_TIMEOUT)
	) i_bit_counter (
		.clk        (clk),
		.rst_n      (rst_n),
		.fall_edge  (fall_edge),
		.frame_done (frame_done)
	);

	scan_translate i_translate (
		.rx_code   (rx_code),
		.set1_code (set1_code),
		.is_break  (is_break)
	);

	port_a_fsm i_port_fsm (
		.clk        (clk),
		.rst_n      (rst_n),
		.frame_done (frame_done),
		.set1_code  (set1_code),
		.is_break   (is_break),
		.pb6        (pb6),
		.pb7        (pb7),
		.pa         (pa),
		.irq1       (irq1)
	);

endmodule

// ==== sim/clk_gen.sv ====
// ==============================
// testbench clock and reset source
// 8 ns clk, rst_n low for the first 5 cycles
// ==============================
`timescale 1ns/1ns

module clk_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk); // release away from the active edge
		rst_n = 1'b1;
	end

endmodule

// ==== sim/kbd_port_checker.sv ====
// ==============================
// protocol assertions for the port A state machine
// bound into port_a_fsm, counts every failed assertion
// ==============================
`timescale 1ns/1ns

module kbd_port_checker (
	input logic                  clk,
	input logic                  rst_n,
	input kbd_pkg::port_state_e  state,
	input logic                  frame_done,
	input kbd_pkg::scan_code_t   pa,
	input logic                  irq1
);
	import kbd_pkg::*;

	int unsigned assert_fails = 0; // read by the testbench at the end

	// the PC reads pa while irq1 is up
	pa_held: assert property (@(posedge clk) disable iff (!rst_n)
		irq1 && $past(irq1) |-> $stable(pa))
		else begin
			$error("pa changed while irq1 stayed high");
			assert_fails++;
		end

	idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		state == st_idle |-> !irq1)
		else begin
			$error("irq1 high in the idle state");
			assert_fails++;
		end

	// no keyboard traffic expected while the PC holds reset
	no_frame_in_reset: assert property (@(posedge clk) disable iff (!rst_n)
		state == st_reset_low |-> !frame_done)
		else begin
			$error("frame completed during keyboard reset");
			assert_fails++;
		end

endmodule

bind port_a_fsm kbd_port_checker i_checker (
	.clk        (clk),
	.rst_n      (rst_n),
	.state      (state),
	.frame_done (frame_done),
	.pa         (pa),
	.irq1       (irq1)
);

// ==== sim/tb_kbd_port.sv ====
// ==============================
// testbench for the PC keyboard port
// sends random PS/2 frames, models the set 2 to set 1 result
// and walks the pb7 clear and pb6 reset protocols
// ==============================
`timescale 1ns/1ns

module tb_kbd_port;
	import kbd_pkg::*;

	localparam int NUM_TESTS = 6;
	localparam int FRAMES_PER_TEST = 20;
	localparam int CYCLE_LIMIT = NUM_TESTS * FRAMES_PER_TEST * 300;
	localparam int HALF_BIT = 8;   // clk cycles per keyboard clock half period
	localparam int IRQ_WAIT = 200;

	// expected set 1 codes for set 2 codes 00 to 7f
	localparam scan_code_t MODEL_TABLE [128] = '{
		8'hff, 8'h43, 8'h41, 8'h3f, 8'h3d, 8'h3b, 8'h3c, 8'h58,
		8'h64, 8'h44, 8'h42, 8'h40, 8'h3e, 8'h0f, 8'h29, 8'h59,
		8'h65, 8'h38, 8'h2a, 8'h70, 8'h1d, 8'h10, 8'h02, 8'h5a,
		8'h66, 8'h71, 8'h2c, 8'h1f, 8'h1e, 8'h11, 8'h03, 8'h5b,
		8'h67, 8'h2e, 8'h2d, 8'h20, 8'h12, 8'h05, 8'h04, 8'h5c,
		8'h68, 8'h39, 8'h2f, 8'h21, 8'h14, 8'h13, 8'h06, 8'h5d,
		8'h69, 8'h31, 8'h30, 8'h23, 8'h22, 8'h15, 8'h07, 8'h5e,
		8'h6a, 8'h72, 8'h32, 8'h24, 8'h16, 8'h08, 8'h09, 8'h5f,
		8'h6b, 8'h33, 8'h25, 8'h17, 8'h18, 8'h0b, 8'h0a, 8'h60,
		8'h6c, 8'h34, 8'h35, 8'h26, 8'h27, 8'h19, 8'h0c, 8'h61,
		8'h6d, 8'h73, 8'h28, 8'h74, 8'h1a, 8'h0d, 8'h62, 8'h6e,
		8'h3a, 8'h36, 8'h1c, 8'h1b, 8'h75, 8'h2b, 8'h63, 8'h76,
		8'h55, 8'h56, 8'h77, 8'h78, 8'h79, 8'h7a, 8'h0e, 8'h7b,
		8'h7c, 8'h4f, 8'h7d, 8'h4b, 8'h47, 8'h7e, 8'h7f, 8'h6f,
		8'h52, 8'h53, 8'h50, 8'h4c, 8'h4d, 8'h48, 8'h01, 8'h45,
		8'h57, 8'h4e, 8'h51, 8'h4a, 8'h37, 8'h49, 8'h46, 8'h54
	};

	logic clk;
	logic rst_n;
	logic ps2_clk;
	logic ps2_data;
	logic pb6;
	logic pb7;
	scan_code_t pa;
	logic irq1;

	logic [15:0] lfsr_state;
	int errors = 0;
	int test_errors = 0;
	int tests_failed = 0;
	int test_num = 0;
	int cycle_count = 0;

	clk_gen i_clk_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	kbd_port_top #(
		.IDLE_TIMEOUT (64)
	) i_dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.ps2_clk  (ps2_clk),
		.ps2_data (ps2_data),
		.pb6      (pb6),
		.pb7      (pb7),
		.pa       (pa),
		.irq1     (irq1)
	);

	// galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {1'b0, s[15:1]} ^ (s[0] ? 16'hb400 : 16'h0000);
	endfunction

	task automatic draw_bits(input int n, output logic [7:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			value[i] = lfsr_state[0]; // bit shifted out
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic random_code(output scan_code_t code);
		logic [7:0] value;
		draw_bits(8, value);
		while (value == BREAK_PREFIX)
			draw_bits(8, value);
		code = value;
	endtask

	// set 1 result the PC expects for one set 2 code
	function automatic scan_code_t model_translate(input scan_code_t code);
		if (!code[7])
			return MODEL_TABLE[code[6:0]];
		if (code == 8'h83)
			return 8'h41;
		if (code == 8'h84)
			return 8'h54;
		return code;
	endfunction

	task automatic wait_falls(input int n);
		repeat (n) @(negedge clk);
	endtask

	// one keyboard clock period per bit, data set up half a period early
	task automatic send_bits(input logic [10:0] bits, input int count);
		for (int i = 0; i < count; i++) begin
			ps2_data = bits[i];
			wait_falls(HALF_BIT);
			ps2_clk = 1'b0;
			wait_falls(HALF_BIT);
			ps2_clk = 1'b1;
		end
		ps2_data = 1'b1;
	endtask

	task automatic send_frame(input scan_code_t code);
		logic [10:0] frame;
		frame = {1'b1, ~^code, code, 1'b0}; // stop, odd parity, data, start
		send_bits(frame, 11);
	endtask

	task automatic report_failure(input string msg);
		$display("%s", msg);
		errors++;
		test_errors++;
	endtask

	task automatic check_code(input string name, input scan_code_t got, input scan_code_t exp);
		if (got !== exp)
			report_failure($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic check_irq(input logic got, input logic exp);
		if (got !== exp)
			report_failure($sformatf("Mismatch irq1: got %h expected %h", got, exp));
	endtask

	task automatic expect_result(input scan_code_t exp);
		bit seen;
		seen = 1'b0;
		for (int i = 0; i < IRQ_WAIT && !seen; i++) begin
			if (irq1)
				seen = 1'b1;
			else
				@(negedge clk);
		end
		if (!seen)
			report_failure($sformatf("irq1 did not rise within %0d cycles of the frame end",
				IRQ_WAIT));
		else
			check_code("pa", pa, exp);
	endtask

	// pb7 high drops irq1 and keeps pa, pb7 low empties pa
	task automatic clear_port(input scan_code_t exp, input int hold);
		pb7 = 1'b1;
		wait_falls(hold);
		check_irq(irq1, 1'b0);
		check_code("pa", pa, exp);
		pb7 = 1'b0;
		wait_falls(3);
		check_code("pa", pa, 8'h00);
	endtask

	task automatic start_test();
		test_num++;
		test_errors = 0;
	endtask

	task automatic end_test(input string name);
		if (test_errors == 0) begin
			$display("test %0d %s: ok", test_num, name);
		end else begin
			$display("test %0d %s: %0d errors", test_num, name, test_errors);
			tests_failed++;
		end
	endtask

	// run limit from the test lengths
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: run passed %0d clock cycles", CYCLE_LIMIT);
			$display("Done: errors found");
			$finish;
		end
	end

	initial begin
		scan_code_t code;
		scan_code_t expected;
		logic [7:0] bits;
		int unsigned assert_fails;
		lfsr_state = 16'd64;
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		pb6 = 1'b1;
		pb7 = 1'b0;
		@(posedge rst_n);
		wait_falls(2);

		start_test();
		check_code("pa", pa, 8'h00);
		check_irq(irq1, 1'b0);
		end_test("reset values");

		start_test();
		for (int n = 0; n < FRAMES_PER_TEST; n++) begin
			random_code(code);
			expected = model_translate(code);
			send_frame(code);
			expect_result(expected);
			clear_port(expected, 3);
		end
		end_test("make codes");

		start_test();
		for (int n = 0; n < FRAMES_PER_TEST; n++) begin
			random_code(code);
			expected = model_translate(code) | 8'h80;
			send_frame(BREAK_PREFIX);
			wait_falls(16);
			check_irq(irq1, 1'b0); // prefix alone is not reported
			send_frame(code);
			expect_result(expected);
			clear_port(expected, 3);
		end
		end_test("break codes");

		start_test();
		for (int n = 0; n < FRAMES_PER_TEST; n++) begin
			random_code(code);
			expected = model_translate(code);
			send_frame(code);
			expect_result(expected);
			wait_falls(20);
			check_irq(irq1, 1'b1); // held until the PC raises pb7
			clear_port(expected, 12); // long pb7 pulse
		end
		end_test("clear protocol");

		start_test();
		for (int n = 0; n < 3; n++) begin
			pb7 = 1'b1;
			pb6 = 1'b0;
			wait_falls(10);
			check_irq(irq1, 1'b0);
			pb6 = 1'b1;
			wait_falls(5);
			check_irq(irq1, 1'b0); // still waiting for pb7 low
			pb7 = 1'b0;
			expect_result(SELF_TEST_OK);
			clear_port(SELF_TEST_OK, 4);
		end
		end_test("keyboard reset");

		start_test();
		for (int n = 0; n < 10; n++) begin
			draw_bits(4, bits);
			send_bits({7'b0, bits[3:0]}, 4);
			wait_falls(80);
			random_code(code);
			expected = model_translate(code);
			send_frame(code);
			expect_result(expected);
			clear_port(expected, 3);
		end
		end_test("resync after partial frame");

		wait_falls(4);
		assert_fails = i_dut.i_port_fsm.i_checker.assert_fails;
		$display("tests run %0d, tests failed %0d, check errors %0d, assertion failures %0d",
			test_num, tests_failed, errors, assert_fails);
		if (errors == 0 && assert_fails == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
logic/kbd_pkg.sv
logic/ps2_sampler.sv
logic/ps2_bit_counter.sv
logic/scan_translate.sv
logic/port_a_fsm.sv
logic/kbd_port_top.sv
sim/clk_gen.sv
sim/kbd_port_checker.sv
sim/tb_kbd_port.sv

// ==== run.sh ====
#!/bin/sh
# build the keyboard port testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_kbd_port \
	-f verilog.f -o tb_kbd_port --Mdir obj_dir || exit 1
./obj_dir/tb_kbd_port > sim.log 2>&1
cat sim.log
grep -qx "Done: no errors" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
